// ==== Makefile ====
SRCS := $(shell grep -v '^+' int_pipe_top.f) logic/pipe_config.svh
BIN := obj_dir/Vint_pipe_tb

.PHONY: all run clean

all: $(BIN)

$(BIN): int_pipe_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f int_pipe_top.f \
		--top-module int_pipe_tb -o Vint_pipe_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== int_pipe_top.f ====
+incdir+logic
logic/pipe_types_pkg.sv
logic/pipe_ops_pkg.sv
logic/hazard_ctrl.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/int_pipe_top.sv
sim/tb_clock_gen.sv
sim/int_pipe_tb.sv

// ==== logic/exec_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_stage
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n_i,
    input  wire           issue_valid_i,
    input  wire issue_t   issue_i,
    input  wire xlen_t    rs1_data_i,
    input  wire xlen_t    rs2_data_i,
    input  wire fwd_sel_e fwd_a,
    input  wire fwd_sel_e fwd_b,
    input  wire xlen_t    mem_fwd_i,
    input  wire xlen_t    wb_fwd_i,
    input  wire           ex_hold,
    input  wire           ex_bubble,
    output ex_stage_t     ex_q_o,
    output xlen_t         ex_res_o
);

    logic     ex_valid_q;
    logic     ex_we_q;
    tag_t     ex_tag_q;
    reg_idx_t ex_rd_q;
    mem_op_e  ex_mem_op_q;
    xlen_t    ex_res_q;
    xlen_t    ex_sdata_q;

    xlen_t      op_a;
    xlen_t      rs2_val;
    xlen_t      op_b;
    xlen_t      alu_res;
    logic [5:0] shamt;
    logic       take;

    function automatic xlen_t pick_operand(fwd_sel_e sel, xlen_t rf_val);
        case (sel)
            fwd_ex:  return ex_res_q;
            fwd_mem: return mem_fwd_i;   // load data once acknowledged
            fwd_wb:  return wb_fwd_i;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a    = pick_operand(fwd_a, rs1_data_i);
        rs2_val = pick_operand(fwd_b, rs2_data_i);   // also the store data
        op_b    = (issue_i.src2_sel == src2_imm) ? issue_i.imm : rs2_val;
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (issue_i.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = xlen_t'($signed(op_a) >>> shamt);
            alu_slt:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = xlen_t'(op_a < op_b);
            default:  alu_res = '0;
        endcase
    end

    assign take = issue_valid_i && !ex_bubble;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
            ex_we_q    <= 1'b0;
        end else if (!ex_hold) begin
            ex_valid_q <= take;
            ex_we_q    <= take && issue_i.rd_we && (issue_i.rd != '0)
                          && (issue_i.mem_op != mem_store);   // x0 and stores never write
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_hold) begin
            ex_tag_q    <= issue_i.tag;
            ex_rd_q     <= issue_i.rd;
            ex_mem_op_q <= issue_i.mem_op;
            ex_res_q    <= alu_res;
            ex_sdata_q  <= rs2_val;
        end
    end

    assign ex_q_o = '{
        valid:      ex_valid_q,
        tag:        ex_tag_q,
        rd:         ex_rd_q,
        rd_we:      ex_we_q,
        mem_op:     ex_mem_op_q,
        result:     ex_res_q,
        store_data: ex_sdata_q
    };

    assign ex_res_o = alu_res;   // live result of the op at the issue port

endmodule

`default_nettype wire

// ==== logic/hazard_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire            issue_valid_i,
    input  wire issue_t    issue_i,
    input  wire ex_stage_t ex_q,
    input  wire ex_stage_t mem_q,
    input  wire wb_stage_t wb_q,
    input  wire            mem_busy,
    input  wire            dmem_ack_i,
    output fwd_sel_e       fwd_a,
    output fwd_sel_e       fwd_b,
    output logic           ex_hold,
    output logic           ex_bubble,
    output logic           issue_ready_o
);

    logic use_rs2;
    logic lu_stall;

    function automatic logic ex_hit(reg_idx_t rs);
        return ex_q.valid && ex_q.rd_we && (ex_q.rd == rs);
    endfunction

    function automatic logic mem_hit(reg_idx_t rs);
        return mem_q.valid && mem_q.rd_we && (mem_q.rd == rs);
    endfunction

    function automatic logic wb_hit(reg_idx_t rs);
        return wb_q.valid && wb_q.rd_we && (wb_q.rd == rs);
    endfunction

    // youngest producer wins
    function automatic fwd_sel_e pick_fwd(reg_idx_t rs);
        if (ex_hit(rs))
            return (ex_q.mem_op == mem_load) ? fwd_rf : fwd_ex; // load: stalled below
        if (mem_hit(rs))
            return fwd_mem;                       // unacked load is stalled below
        if (wb_hit(rs))
            return fwd_wb;
        return fwd_rf;
    endfunction

    function automatic logic load_wait(reg_idx_t rs);
        if (ex_hit(rs))
            return ex_q.mem_op == mem_load;       // data two stages away at best
        return mem_hit(rs) && (mem_q.mem_op == mem_load) && !dmem_ack_i;
    endfunction

    always_comb begin
        use_rs2  = (issue_i.src2_sel == src2_reg) || (issue_i.mem_op == mem_store);
        fwd_a    = pick_fwd(issue_i.rs1);
        fwd_b    = pick_fwd(issue_i.rs2);
        lu_stall = load_wait(issue_i.rs1) || (use_rs2 && load_wait(issue_i.rs2));
    end

    assign ex_hold       = mem_busy && !dmem_ack_i;    // memory back-pressure
    assign ex_bubble     = issue_valid_i && lu_stall && !ex_hold;
    assign issue_ready_o = !ex_hold && !lu_stall;

    // x0 has no producer since exec_stage drops rd_we for it
    a_x0_not_fwd: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue_valid_i && (issue_i.rs1 == '0 || issue_i.rs2 == '0) |->
            (issue_i.rs1 != '0 || fwd_a == fwd_rf) && (issue_i.rs2 != '0 || fwd_b == fwd_rf));

    // a bubble empties the execute register
    a_bubble_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_bubble |=> !ex_q.valid);

endmodule

`default_nettype wire

// ==== logic/int_pipe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_pipe_top
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         issue_valid_i,
    input  wire issue_t issue_i,
    output logic        issue_ready_o,
    output logic        dmem_req_o,
    output logic        dmem_we_o,
    output addr_t       dmem_addr_o,
    output xlen_t       dmem_wdata_o,
    input  wire         dmem_ack_i,
    input  wire xlen_t  dmem_rdata_i,
    output retire_t     retire_o
);

    ex_stage_t ex_q;
    ex_stage_t mem_q;
    wb_stage_t wb_q;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      ex_hold;
    logic      ex_bubble;
    logic      mem_busy;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     mem_load_data;

    hazard_ctrl u_hazard (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .ex_q          (ex_q),
        .mem_q         (mem_q),
        .wb_q          (wb_q),
        .mem_busy      (mem_busy),
        .dmem_ack_i    (dmem_ack_i),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .ex_hold       (ex_hold),
        .ex_bubble     (ex_bubble),
        .issue_ready_o (issue_ready_o)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (issue_i.rs1),
        .rs2_i      (issue_i.rs2),
        .wb_i       (wb_q),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_stage u_exec (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_fwd_i     (mem_load_data),
        .wb_fwd_i      (wb_q.data),
        .ex_hold       (ex_hold),
        .ex_bubble     (ex_bubble),
        .ex_q_o        (ex_q),
        .ex_res_o      ()            // not needed past the execute register
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_q_i          (ex_q),
        .dmem_ack_i      (dmem_ack_i),
        .dmem_rdata_i    (dmem_rdata_i),
        .mem_q_o         (mem_q),
        .wb_q_o          (wb_q),
        .mem_busy_o      (mem_busy),
        .mem_load_data_o (mem_load_data),
        .dmem_req_o      (dmem_req_o),
        .dmem_we_o       (dmem_we_o),
        .dmem_addr_o     (dmem_addr_o),
        .dmem_wdata_o    (dmem_wdata_o)
    );

    // writeback register doubles as the retire trace
    assign retire_o = '{valid: wb_q.valid, tag: wb_q.tag, wb_en: wb_q.rd_we,
                        wb_addr: wb_q.rd, wb_data: wb_q.data};

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire ex_stage_t ex_q_i,
    input  wire            dmem_ack_i,
    input  wire xlen_t     dmem_rdata_i,
    output ex_stage_t      mem_q_o,
    output wb_stage_t      wb_q_o,
    output logic           mem_busy_o,
    output xlen_t          mem_load_data_o,
    output logic           dmem_req_o,
    output logic           dmem_we_o,
    output addr_t          dmem_addr_o,
    output xlen_t          dmem_wdata_o
);

    typedef enum logic {st_idle, st_wait_ack} mem_state_e;

    mem_state_e state_q;
    mem_state_e state_d;
    logic       advance;
    logic       ex_is_mem;
    xlen_t      mem_data;

    logic     mem_valid_q;
    logic     mem_we_q;
    tag_t     mem_tag_q;
    reg_idx_t mem_rd_q;
    mem_op_e  mem_op_q;
    xlen_t    mem_res_q;
    xlen_t    mem_sdata_q;

    logic     wb_valid_q;
    logic     wb_we_q;
    tag_t     wb_tag_q;
    reg_idx_t wb_rd_q;
    xlen_t    wb_data_q;

    assign ex_is_mem = ex_q_i.valid && (ex_q_i.mem_op != mem_none);
    assign advance   = (state_q == st_idle) || dmem_ack_i;

    // wait_ack covers exactly the cycles a load/store sits in mem_q unacked
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:     if (ex_is_mem) state_d = st_wait_ack;
            st_wait_ack: if (dmem_ack_i && !ex_is_mem) state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= st_idle;
            mem_valid_q <= 1'b0;
            mem_we_q    <= 1'b0;
            wb_valid_q  <= 1'b0;
            wb_we_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            wb_valid_q <= advance && mem_valid_q;          // bubble while waiting
            wb_we_q    <= advance && mem_valid_q && mem_we_q;
            if (advance) begin
                mem_valid_q <= ex_q_i.valid;
                mem_we_q    <= ex_q_i.valid && ex_q_i.rd_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_tag_q   <= ex_q_i.tag;
            mem_rd_q    <= ex_q_i.rd;
            mem_op_q    <= ex_q_i.mem_op;
            mem_res_q   <= ex_q_i.result;
            mem_sdata_q <= ex_q_i.store_data;
            wb_tag_q    <= mem_tag_q;
            wb_rd_q     <= mem_rd_q;
            wb_data_q   <= mem_data;
        end
    end

    assign mem_data        = (mem_op_q == mem_load) ? dmem_rdata_i : mem_res_q;
    assign mem_load_data_o = mem_data;

    assign mem_busy_o   = (state_q == st_wait_ack);
    assign dmem_req_o   = (state_q == st_wait_ack);
    assign dmem_we_o    = (mem_op_q == mem_store);
    assign dmem_addr_o  = addr_t'(mem_res_q);   // low bits of rs1 + imm
    assign dmem_wdata_o = mem_sdata_q;

    assign mem_q_o = '{
        valid:      mem_valid_q,
        tag:        mem_tag_q,
        rd:         mem_rd_q,
        rd_we:      mem_we_q,
        mem_op:     mem_op_q,
        result:     mem_res_q,
        store_data: mem_sdata_q
    };

    assign wb_q_o = '{valid: wb_valid_q, tag: wb_tag_q, rd: wb_rd_q, rd_we: wb_we_q,
                      data: wb_data_q};

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_we_o)
            && $stable(dmem_addr_o) && $stable(dmem_wdata_o));

    a_no_stray_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_ack_i |-> dmem_req_o);

endmodule

`default_nettype wire

// ==== logic/pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// width of one integer register and of the ALU datapath
`define PIPE_XLEN 64

// architectural register count, x0 included
`define PIPE_NREGS 32

// issue tag carried through to the retire trace
`define PIPE_TAG_W 16

// byte address on the data-memory port
`define PIPE_ADDR_W 32

`endif

// ==== logic/pipe_ops_pkg.sv ====
`default_nettype none

package pipe_ops_pkg;
    import pipe_types_pkg::*;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_e;

    typedef enum logic {src2_reg, src2_imm} src2_sel_e;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {fwd_rf, fwd_ex, fwd_mem, fwd_wb} fwd_sel_e;

    typedef struct packed {
        tag_t      tag;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        logic      rd_we;
        alu_op_e   alu_op;
        src2_sel_e src2_sel;
        xlen_t     imm;
        mem_op_e   mem_op;
    } issue_t;

    // shared by the execute and memory stage registers
    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        logic     rd_we;      // already cleared for x0 and stores
        mem_op_e  mem_op;
        xlen_t    result;     // ALU result, also the load/store address
        xlen_t    store_data;
    } ex_stage_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        logic     rd_we;
        xlen_t    data;
    } wb_stage_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        logic     wb_en;
        reg_idx_t wb_addr;
        xlen_t    wb_data;
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/pipe_types_pkg.sv ====
`default_nettype none

`include "pipe_config.svh"

package pipe_types_pkg;

    // one integer data word
    typedef logic [`PIPE_XLEN-1:0] xlen_t;

    // register index, x0 .. x31
    typedef logic [$clog2(`PIPE_NREGS)-1:0] reg_idx_t;

    // opaque tag in place of the pc
    typedef logic [`PIPE_TAG_W-1:0] tag_t;

    // data-memory byte address
    typedef logic [`PIPE_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipe_config.svh"

module reg_file
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire reg_idx_t  rs1_i,
    input  wire reg_idx_t  rs2_i,
    input  wire wb_stage_t wb_i,
    output xlen_t          rs1_data_o,
    output xlen_t          rs2_data_o
);

    xlen_t regs [`PIPE_NREGS];

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.rd_we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 is never written, so its entry stays unused
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // writes to x0 are filtered at issue, none should reach writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.valid && wb_i.rd_we |-> wb_i.rd != '0);

endmodule

`default_nettype wire

// ==== sim/int_pipe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_pipe_tb
    import pipe_types_pkg::*;
    import pipe_ops_pkg::*;
();

    localparam int N_ALU = 30;
    localparam int N_FWD = 9;
    localparam int N_MEM = 13;
    localparam int N_RAND = 60;
    localparam int N_OPS = N_ALU + N_FWD + N_MEM + N_RAND;
    localparam int WATCHDOG_NS = (N_OPS * 200 + 20) * 20;
    localparam int MAX_OPS = 256;

    logic    clk;
    logic    rst_n;
    logic    issue_valid = 1'b0;
    issue_t  issue = '0;
    logic    issue_ready;
    logic    dmem_req;
    logic    dmem_we;
    addr_t   dmem_addr;
    xlen_t   dmem_wdata;
    logic    dmem_ack = 1'b0;
    xlen_t   dmem_rdata = '0;
    retire_t retire;

    integer seed = 32'ha989;
    int     accept_cnt = 0;
    int     retire_cnt = 0;
    int     mem_cnt = 0;
    int     mexp_cnt = 0;
    int     tag_cnt = 0;
    int     ack_wait = 0;
    int     delay;
    logic   started = 1'b0;
    logic   ret_seen = 1'b0;
    logic   req_s = 1'b0;
    logic   resp_busy = 1'b0;

    xlen_t    gold_rf [32] = '{default: '0};
    xlen_t    gold_mem [addr_t];
    xlen_t    resp_mem [addr_t];
    tag_t     exp_tag [MAX_OPS];
    logic     exp_en [MAX_OPS];
    reg_idx_t exp_addr [MAX_OPS];
    xlen_t    exp_data [MAX_OPS];
    logic     mexp_we [MAX_OPS];
    addr_t    mexp_addr [MAX_OPS];
    xlen_t    mexp_wdata [MAX_OPS];

    tb_clock_gen u_clk (.clk(clk), .rst_n_o(rst_n));

    int_pipe_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .issue_ready_o (issue_ready),
        .dmem_req_o    (dmem_req),
        .dmem_we_o     (dmem_we),
        .dmem_addr_o   (dmem_addr),
        .dmem_wdata_o  (dmem_wdata),
        .dmem_ack_i    (dmem_ack),
        .dmem_rdata_i  (dmem_rdata),
        .retire_o      (retire)
    );

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // unwritten memory returns a word built from the full address
    function automatic xlen_t fill_word(addr_t a);
        return {a ^ 32'h5a5a_0f0f, ~a};
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xlen_t alu_ref(alu_op_e f, xlen_t a, xlen_t b);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[5:0];
            alu_srl:  return a >> b[5:0];
            alu_sra:  return xlen_t'($signed(a) >>> b[5:0]);
            alu_slt:  return {63'd0, $signed(a) < $signed(b)};
            alu_sltu: return {63'd0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic issue_t make_op(alu_op_e f, int rd, int rs1, int rs2, logic use_imm,
                                       xlen_t imm, mem_op_e m);
        issue_t op;
        op.tag      = '0;
        op.rs1      = reg_idx_t'(rs1);
        op.rs2      = reg_idx_t'(rs2);
        op.rd       = reg_idx_t'(rd);
        op.rd_we    = (m != mem_store);
        op.alu_op   = f;
        op.src2_sel = use_imm ? src2_imm : src2_reg;
        op.imm      = imm;
        op.mem_op   = m;
        return op;
    endfunction

    // golden model, applied in issue order
    task automatic record_op(issue_t op);
        xlen_t a;
        xlen_t b;
        xlen_t res;
        addr_t ad;
        logic  en;
        a   = gold_rf[op.rs1];
        b   = (op.src2_sel == src2_imm) ? op.imm : gold_rf[op.rs2];
        res = alu_ref(op.alu_op, a, b);
        ad  = res[31:0];
        if (op.mem_op != mem_none) begin
            mexp_we[mexp_cnt]    = (op.mem_op == mem_store);
            mexp_addr[mexp_cnt]  = ad;
            mexp_wdata[mexp_cnt] = gold_rf[op.rs2];
            mexp_cnt++;
        end
        if (op.mem_op == mem_store)
            gold_mem[ad] = gold_rf[op.rs2];
        else if (op.mem_op == mem_load)
            res = gold_mem.exists(ad) ? gold_mem[ad] : fill_word(ad);
        en = op.rd_we && (op.rd != '0) && (op.mem_op != mem_store);
        if (en)
            gold_rf[op.rd] = res;
        exp_tag[accept_cnt]  = op.tag;
        exp_en[accept_cnt]   = en;
        exp_addr[accept_cnt] = op.rd;
        exp_data[accept_cnt] = res;
        accept_cnt++;
        started = 1'b1;
    endtask

    task automatic send(issue_t op);
        logic rdy;
        op.tag      = tag_t'(tag_cnt);
        tag_cnt++;
        issue       = op;
        issue_valid = 1'b1;
        do begin
            @(negedge clk);
            rdy = issue_ready;      // stable mid-cycle
            @(posedge clk);
        end while (!rdy);
        record_op(op);
        #2 issue_valid = 1'b0;
    endtask

    task automatic idle(int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #2;
        end
    endtask

    task automatic check_alu();
        alu_op_e f;
        for (int r = 1; r <= 8; r++)
            send(make_op(alu_add, r, 0, 0, 1'b1, rand64(), mem_none));
        for (int k = 0; k < 10; k++) begin
            f = alu_op_e'(4'(k));
            send(make_op(f, 9 + k, 1 + k % 8, 1 + (k + 3) % 8, 1'b0, '0, mem_none));
            send(make_op(f, 19 + k, 1 + (k + 5) % 8, 0, 1'b1, rand64(), mem_none));
        end
        send(make_op(alu_xor, 0, 1, 2, 1'b0, '0, mem_none));   // x0 destination
        send(make_op(alu_or, 29, 0, 0, 1'b0, '0, mem_none));
    endtask

    task automatic check_forwarding();
        for (int d = 1; d <= 3; d++) begin
            send(make_op(alu_add, 10, 1, 0, 1'b1, rand64(), mem_none));
            for (int j = 1; j < d; j++)
                send(make_op(alu_xor, 20 + j, 2, 3, 1'b0, '0, mem_none));
            send(make_op(alu_add, 11, 10, 10, 1'b0, '0, mem_none));   // both ports
        end
    endtask

    task automatic check_memory();
        xlen_t ad;
        for (int k = 0; k < 4; k++) begin
            ad = xlen_t'({$random(seed)} & 32'hffff_fff8);
            send(make_op(alu_add, 0, 0, 1 + k, 1'b1, ad, mem_store));
            send(make_op(alu_add, 12, 0, 0, 1'b1, ad, mem_load));
            send(make_op(alu_add, 13, 12, 12, 1'b0, '0, mem_none));   // load-use
        end
        send(make_op(alu_add, 14, 0, 0, 1'b1, ad + 64, mem_load));
    endtask

    task automatic check_random();
        int    kind;
        int    gap;
        xlen_t slot;
        for (int n = 0; n < N_RAND; n++) begin
            kind = $random(seed) & 7;
            slot = xlen_t'(32'h1000 + 8 * ($random(seed) & 3));
            if (kind == 0)
                send(make_op(alu_add, 0, 0, $random(seed) & 7, 1'b1, slot, mem_store));
            else if (kind < 3)
                send(make_op(alu_add, $random(seed) & 7, 0, 0, 1'b1, slot, mem_load));
            else
                send(make_op(alu_op_e'(4'($unsigned($random(seed)) % 10)),
                             $random(seed) & 7, $random(seed) & 7, $random(seed) & 7,
                             kind[0], rand64(), mem_none));
            gap = $random(seed) & 3;
            idle(gap == 3 ? 0 : gap);
        end
    endtask

    // memory responder, ack 1 to 4 cycles after the request rises
    always @(negedge clk) req_s <= dmem_req;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_busy <= 1'b0;
            ack_wait  <= 0;
            dmem_ack  <= 1'b0;
        end else if (dmem_ack) begin
            dmem_ack  <= #2 1'b0;
            resp_busy <= 1'b0;
            mem_cnt   <= mem_cnt + 1;
        end else if (resp_busy || req_s) begin
            delay     = resp_busy ? ack_wait : ($random(seed) & 3);
            resp_busy <= 1'b1;
            if (delay == 0) begin
                dmem_ack <= #2 1'b1;
                if (dmem_we)
                    resp_mem[dmem_addr] = dmem_wdata;
                else
                    dmem_rdata <= #2 resp_mem.exists(dmem_addr) ? resp_mem[dmem_addr]
                                                                 : fill_word(dmem_addr);
            end else begin
                ack_wait <= delay - 1;
            end
        end
    end

    always @(negedge clk) ret_seen <= retire.valid;
    always @(posedge clk) if (ret_seen) retire_cnt <= retire_cnt + 1;

    a_idle_after_reset: assert property (@(negedge clk) disable iff (!rst_n)
        !started |-> issue_ready && !dmem_req && !retire.valid)
        else stop_with_error("DUT not idle after reset before the first operation");

    a_no_extra_retire: assert property (@(negedge clk) disable iff (!rst_n)
        retire.valid |-> retire_cnt < accept_cnt)
        else stop_with_error("retirement without a matching accepted operation");

    a_retire_tag: assert property (@(negedge clk) disable iff (!rst_n)
        retire.valid |-> retire.tag == exp_tag[retire_cnt])
        else stop_with_error($sformatf("error: retire_o.tag %h expected %h",
                                       retire.tag, exp_tag[retire_cnt]));

    a_retire_en: assert property (@(negedge clk) disable iff (!rst_n)
        retire.valid |-> retire.wb_en == exp_en[retire_cnt])
        else stop_with_error($sformatf("error: retire_o.wb_en %h expected %h",
                                       retire.wb_en, exp_en[retire_cnt]));

    a_retire_addr: assert property (@(negedge clk) disable iff (!rst_n)
        retire.valid && retire.wb_en |-> retire.wb_addr == exp_addr[retire_cnt])
        else stop_with_error($sformatf("error: retire_o.wb_addr %h expected %h",
                                       retire.wb_addr, exp_addr[retire_cnt]));

    a_retire_data: assert property (@(negedge clk) disable iff (!rst_n)
        retire.valid && retire.wb_en |-> retire.wb_data == exp_data[retire_cnt])
        else stop_with_error($sformatf("error: retire_o.wb_data %h expected %h",
                                       retire.wb_data, exp_data[retire_cnt]));

    // held for the whole request, so stability is covered too
    a_mem_addr: assert property (@(negedge clk) disable iff (!rst_n)
        dmem_req |-> mem_cnt < mexp_cnt && dmem_we == mexp_we[mem_cnt]
            && dmem_addr == mexp_addr[mem_cnt])
        else stop_with_error($sformatf("error: dmem_addr_o %h we %h expected %h we %h",
                             dmem_addr, dmem_we, mexp_addr[mem_cnt], mexp_we[mem_cnt]));

    a_mem_wdata: assert property (@(negedge clk) disable iff (!rst_n)
        dmem_req && dmem_we |-> dmem_wdata == mexp_wdata[mem_cnt])
        else stop_with_error($sformatf("error: dmem_wdata_o %h expected %h",
                                       dmem_wdata, mexp_wdata[mem_cnt]));

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("timeout, the pipeline stopped retiring operations");
    end

    initial begin
        @(posedge rst_n);
        @(posedge clk);
        #2;
        check_alu();
        check_forwarding();
        check_memory();
        check_random();
        wait (retire_cnt == accept_cnt && mem_cnt == mexp_cnt);
        repeat (5) @(posedge clk);
        if (retire_cnt == accept_cnt && accept_cnt == N_OPS) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_error("retire count does not match the issued operations");
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire
